//--- Bender.yml
package:
  name: cpc_loader_mf2

export_include_dirs:
  - logic

sources:
  - files:
      - logic/loader_pkg.sv
      - logic/mf2_pkg.sv
      - logic/cpc_ifs.sv
      - logic/ext_page_decode.sv
      - logic/boot_addr_map.sv
      - logic/mf2_control.sv
      - logic/mf2_shadow_ram.sv
      - logic/cpc_loader_mf2.sv
  - target: test
    files:
      - sim/cpc_chk.sv
      - sim/cpc_tb.sv

//--- build.f
+incdir+logic
logic/loader_pkg.sv
logic/mf2_pkg.sv
logic/cpc_ifs.sv
logic/ext_page_decode.sv
logic/boot_addr_map.sv
logic/mf2_control.sv
logic/mf2_shadow_ram.sv
logic/cpc_loader_mf2.sv
sim/cpc_chk.sv
sim/cpc_tb.sv

//--- logic/boot_addr_map.sv
// Maps the download stream onto the SDRAM layout and keeps the map of loaded ROM pages
// Lower 4 MB hold OS, RAM and MF2 ROM, upper 4 MB hold up to 256 upper-ROM pages
`timescale 1ns/1ps
`default_nettype none

module boot_addr_map (
	input  logic                   clk_sys,
	input  logic                   reset,
	download_if.loader_sink        dl,
	input  loader_pkg::page_t      page_i,
	input  logic                   model_i,
	output logic                   boot_wr_o,
	output loader_pkg::boot_addr_t boot_a_o,
	output loader_pkg::boot_bank_t boot_bank_o,
	output loader_pkg::rom_map_t   rom_map_o,
	output logic                   write_done_o,
	output loader_pkg::boot_addr_t boot_a_fb_o
);
	import loader_pkg::*;

	logic       rom_dl;
	logic       ext_dl;
	logic       old_wr;
	logic       wr_fall;
	boot_addr_t boot_a;
	rom_map_t   rom_map;

	assign rom_dl  = dl.download & (dl.index == DL_ROM);
	assign ext_dl  = dl.download & (dl.index == DL_EXT);
	assign wr_fall = (rom_dl | ext_dl) & old_wr & ~dl.wr;

	always_comb begin
		boot_wr_o    = (rom_dl | ext_dl) & dl.wr;
		boot_a       = '1;
		boot_a[13:0] = dl.addr[13:0];
		boot_bank_o  = '0;
		if (ext_dl) begin
			boot_a[22]    = page_i[8];
			boot_a[21:14] = page_i[7:0] + dl.addr[21:14];
			boot_bank_o   = {1'b0, model_i};
		end else begin
			case (dl.addr[24:14])     // 16 KB block of the ROM file
				11'd0, 11'd4: boot_a[22:14] = 9'h000;  // OS
				11'd1, 11'd5: boot_a[22:14] = 9'h100;  // BASIC
				11'd2, 11'd6: boot_a[22:14] = 9'h107;  // AMSDOS
				11'd3, 11'd7: boot_a[22:14] = 9'h0FF;  // MF2
				default:      boot_wr_o     = 1'b0;
			endcase
			// Second set of four blocks is the 664 image
			if (dl.addr[24:14] inside {[11'd4:11'd7]})
				boot_bank_o = 2'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		old_wr <= dl.wr;
		if (reset) begin
			write_done_o <= 1'b0;
			rom_map      <= '0;
		end else begin
			write_done_o <= wr_fall;
			if (write_done_o && boot_a_fb_o[22])
				rom_map[boot_a_fb_o[21:14]] <= 1'b1;
		end
	end

	// Address of the write that just ended
	always_ff @(posedge clk_sys) begin
		if (wr_fall)
			boot_a_fb_o <= boot_a;
	end

	assign boot_a_o  = boot_a;
	assign rom_map_o = rom_map;

endmodule

`default_nettype wire

//--- logic/cpc_cfg.svh
// Widths, special pages and port addresses shared by the loader and the Multiface
// Include wherever one of these values is needed
`ifndef CPC_CFG_SVH
`define CPC_CFG_SVH

//////////////////////////////
// Download and boot side

`define CPC_IOCTL_AW   25       // Download address bits
`define CPC_BOOT_AW    23       // SDRAM boot address bits
`define CPC_PAGE_W     9        // Page number, bit 8 selects the upper ROM half
`define CPC_ROM_PAGES  256      // Upper-ROM pages tracked in the map

// Unused page, target of a malformed extension
`define CPC_PAGE_BAD   9'h1EE

// Second half of a combined image continues here
`define CPC_PAGE_COMBO 9'h1FF

//////////////////////////////
// Multiface Two

`define CPC_MF2_AW     13       // 8 KB RAM

// FEE8 and FEEA share the upper 14 address bits
`define CPC_MF2_PORT   14'h3FBA

`endif

//--- logic/cpc_ifs.sv
// Bundles used inside the design
// download_if carries the host download stream, cpu_bus_if the Z80 side
`timescale 1ns/1ps
`default_nettype none

`include "cpc_cfg.svh"

interface download_if;
	import loader_pkg::*;

	logic                     wr;
	logic [`CPC_IOCTL_AW-1:0] addr;
	logic [7:0]               dout;
	logic                     download;
	logic [7:0]               index;
	file_ext_t                file_ext;

	// Driven from the top level ports
	modport src (
		output wr, addr, dout, download, index, file_ext
	);

	modport loader_sink (
		input wr, addr, dout, download, index, file_ext
	);
endinterface

interface cpu_bus_if;
	logic [15:0] addr;
	logic [7:0]  dout;     // CPU write data
	logic        m1;       // Opcode fetch
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;

	modport mf2_sink (
		input addr, dout, m1, io_wr, mem_rd, mem_wr
	);
endinterface

`default_nettype wire

//--- logic/cpc_loader_mf2.sv
// Top level of the download loader and the Multiface Two
// Bundles the plain ports into the two interfaces and connects the four blocks
`timescale 1ns/1ps
`default_nettype none

`include "cpc_cfg.svh"

module cpc_loader_mf2 (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_wr_i,
	input  logic [`CPC_IOCTL_AW-1:0] ioctl_addr_i,
	input  logic [7:0]               ioctl_dout_i,
	input  logic                     ioctl_download_i,
	input  logic [7:0]               ioctl_index_i,
	input  loader_pkg::file_ext_t    ioctl_file_ext_i,
	input  logic                     model_i,
	input  logic [15:0]              cpu_addr_i,
	input  logic [7:0]               cpu_dout_i,
	input  logic                     m1_i,
	input  logic                     io_wr_i,
	input  logic                     mem_rd_i,
	input  logic                     mem_wr_i,
	input  logic                     key_nmi_i,
	input  mf2_pkg::mf2_mode_e       mf2_mode_i,
	output logic                     boot_wr_o,
	output loader_pkg::boot_addr_t   boot_a_o,
	output loader_pkg::boot_bank_t   boot_bank_o,
	output logic [7:0]               boot_dout_o,
	output loader_pkg::rom_map_t     rom_map_o,
	output logic                     mf2_nmi_o,
	output logic                     mf2_rom_en_o,
	output logic                     mf2_ram_en_o,
	output logic [7:0]               mf2_dout_o
);
	import loader_pkg::*;

	page_t      page;
	logic       write_done;
	boot_addr_t boot_a_fb;
	logic       mf2_en;
	logic       hw_wr;

	download_if dl ();
	cpu_bus_if  bus ();

	assign dl.wr       = ioctl_wr_i;
	assign dl.addr     = ioctl_addr_i;
	assign dl.dout     = ioctl_dout_i;
	assign dl.download = ioctl_download_i;
	assign dl.index    = ioctl_index_i;
	assign dl.file_ext = ioctl_file_ext_i;
	assign boot_dout_o = dl.dout;          // Download data goes to SDRAM unchanged

	assign bus.addr   = cpu_addr_i;
	assign bus.dout   = cpu_dout_i;
	assign bus.m1     = m1_i;
	assign bus.io_wr  = io_wr_i;
	assign bus.mem_rd = mem_rd_i;
	assign bus.mem_wr = mem_wr_i;

	//////////////////////////////
	// Loader

	ext_page_decode u_ext_page (
		.clk_sys(clk_sys), .reset(reset), .dl(dl),
		.write_done_i(write_done), .boot_a_i(boot_a_fb), .page_o(page)
	);

	boot_addr_map u_boot_map (
		.clk_sys(clk_sys), .reset(reset), .dl(dl), .page_i(page), .model_i(model_i),
		.boot_wr_o(boot_wr_o), .boot_a_o(boot_a_o), .boot_bank_o(boot_bank_o),
		.rom_map_o(rom_map_o), .write_done_o(write_done), .boot_a_fb_o(boot_a_fb)
	);

	//////////////////////////////
	// Multiface Two

	mf2_control u_mf2_ctrl (
		.clk_sys(clk_sys), .reset(reset), .bus(bus), .key_nmi_i(key_nmi_i),
		.mode_i(mf2_mode_i), .mf2_nmi_o(mf2_nmi_o), .mf2_en_o(mf2_en), .hw_wr_o(hw_wr)
	);

	mf2_shadow_ram u_mf2_ram (
		.clk_sys(clk_sys), .reset(reset), .bus(bus), .mf2_en_i(mf2_en), .hw_wr_i(hw_wr),
		.ram_en_o(mf2_ram_en_o), .rom_en_o(mf2_rom_en_o), .dout_o(mf2_dout_o)
	);

endmodule

`default_nettype wire

//--- logic/ext_page_decode.sv
// Start page of an expansion download, taken from the two hex characters of its extension
// Also moves a combined image on to page 1FF once its first 16 KB are written
`timescale 1ns/1ps
`default_nettype none

`include "cpc_cfg.svh"

module ext_page_decode (
	input  logic                   clk_sys,
	input  logic                   reset,
	download_if.loader_sink        dl,
	input  logic                   write_done_i,
	input  loader_pkg::boot_addr_t boot_a_i,
	output loader_pkg::page_t      page_o
);
	import loader_pkg::*;

	logic       old_download;
	logic       ext_start;
	logic       combo;          // Armed by a Z0 image
	logic       is_z0;
	logic [4:0] hi_char;
	logic [4:0] lo_char;
	page_t      ext_page;
	page_t      page;

	// Bit 4 set when the character is a hex digit
	function automatic logic [4:0] hex_char(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign ext_start = ~old_download & dl.download & (dl.index == DL_EXT);
	assign hi_char   = hex_char(dl.file_ext[15:8]);
	assign lo_char   = hex_char(dl.file_ext[7:0]);
	assign is_z0     = (dl.file_ext[15:0] == "Z0");

	// Each valid digit overwrites its nibble of the bad page
	always_comb begin
		ext_page = `CPC_PAGE_BAD;
		if (hi_char[4]) ext_page[7:4] = hi_char[3:0];
		if (lo_char[4]) ext_page[3:0] = lo_char[3:0];
		if (dl.file_ext[15:0] == "ZZ" || is_z0)
			ext_page = '0;        // Replaces the OS area
	end

	always_ff @(posedge clk_sys) begin
		old_download <= dl.download;
		if (reset) begin
			combo <= 1'b0;
			page  <= '0;
		end else if (ext_start) begin
			page  <= ext_page;
			combo <= is_z0;
		end else if (combo && write_done_i && (&boot_a_i[13:0])) begin
			page  <= `CPC_PAGE_COMBO;  // Last byte of the first 16 KB
			combo <= 1'b0;
		end
	end

	assign page_o = page;

endmodule

`default_nettype wire

//--- logic/loader_pkg.sv
// Types for the ROM and expansion download loader
// Imported by the loader modules and the download interface
`default_nettype none

`include "cpc_cfg.svh"

package loader_pkg;

	// Download index as sent by the host
	typedef enum logic [7:0] {
		DL_ROM  = 8'd0,
		DL_DISK = 8'd1,
		DL_EXT  = 8'd3,
		DL_TAPE = 8'd4
	} dl_kind_e;

	typedef logic [`CPC_BOOT_AW-1:0]   boot_addr_t;
	typedef logic [`CPC_PAGE_W-1:0]    page_t;
	typedef logic [1:0]                boot_bank_t;
	typedef logic [`CPC_ROM_PAGES-1:0] rom_map_t;   // One bit per loaded upper-ROM page
	typedef logic [23:0]               file_ext_t;  // Three ASCII characters

endpackage

`default_nettype wire

//--- logic/mf2_control.sv
// Multiface Two NMI capture, enable and hide control
// Also flags io writes that are not aimed at the FEE8/FEEA port
`timescale 1ns/1ps
`default_nettype none

`include "cpc_cfg.svh"

module mf2_control (
	input  logic                clk_sys,
	input  logic                reset,
	cpu_bus_if.mf2_sink         bus,
	input  logic                key_nmi_i,
	input  mf2_pkg::mf2_mode_e  mode_i,
	output logic                mf2_nmi_o,
	output logic                mf2_en_o,
	output logic                hw_wr_o
);
	import mf2_pkg::*;

	logic old_key_nmi;
	logic old_m1;
	logic old_io_wr;
	logic key_rise;
	logic m1_rise;
	logic io_rise;
	logic port_hit;
	logic mf2_off;
	logic nmi;
	logic en;
	logic hidden;

	assign key_rise = ~old_key_nmi & key_nmi_i;
	assign m1_rise  = ~old_m1 & bus.m1;
	assign io_rise  = ~old_io_wr & bus.io_wr;
	assign port_hit = (bus.addr[15:2] == `CPC_MF2_PORT);
	assign mf2_off  = (mode_i == MF2_DISABLED);

	always_ff @(posedge clk_sys) begin
		old_key_nmi <= key_nmi_i;
		old_m1      <= bus.m1;
		old_io_wr   <= bus.io_wr;
		if (reset) begin
			nmi    <= 1'b0;
			en     <= 1'b0;
			hidden <= (mode_i != MF2_ENABLED);
		end else begin
			if (key_rise && !en && !mf2_off)
				nmi <= 1'b1;                       // Freeze button
			if (nmi && m1_rise && bus.addr == 16'h0066) begin
				en     <= 1'b1;                    // NMI vector fetched
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (en && m1_rise && bus.addr == 16'h0065)
				hidden <= 1'b1;                    // Return path of the MF2 ROM
			// FEE8 pages in, FEEA pages out
			if (io_rise && port_hit)
				en <= ~bus.addr[1] & ~hidden & ~mf2_off;
		end
	end

	assign mf2_nmi_o = nmi;
	assign mf2_en_o  = en;
	assign hw_wr_o   = io_rise & ~port_hit;  // Candidate for a shadow copy

endmodule

`default_nettype wire

//--- logic/mf2_pkg.sv
// Types for the Multiface Two control logic and its shadow RAM
// Imported by the Multiface modules
`default_nettype none

`include "cpc_cfg.svh"

package mf2_pkg;

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_e;

	typedef logic [`CPC_MF2_AW-1:0] mf2_addr_t;

	// Where each hardware register copy lives in the RAM
	typedef enum logic [`CPC_MF2_AW-1:0] {
		SLOT_NONE      = 13'h0000,
		SLOT_PPI       = 13'h17FF,  // 8255 control
		SLOT_UROM      = 13'h1AAC,  // Upper ROM select
		SLOT_CRTC_SEL  = 13'h1CFF,
		SLOT_CRTC_BASE = 13'h1DB0,  // 16 CRTC registers
		SLOT_PEN_BASE  = 13'h1F90,  // 16 pen colors
		SLOT_PEN       = 13'h1FCF,
		SLOT_BORDER    = 13'h1FDF,
		SLOT_MODE      = 13'h1FEF,
		SLOT_BANK      = 13'h1FFF
	} mf2_slot_e;

endpackage

`default_nettype wire

//--- logic/mf2_shadow_ram.sv
// Multiface Two 8 KB RAM with copies of the gate array, CRTC, 8255 and ROM select writes
// Read data follows the address by two cycles
`timescale 1ns/1ps
`default_nettype none

`include "cpc_cfg.svh"

module mf2_shadow_ram (
	input  logic         clk_sys,
	input  logic         reset,
	cpu_bus_if.mf2_sink  bus,
	input  logic         mf2_en_i,
	input  logic         hw_wr_i,
	output logic         ram_en_o,
	output logic         rom_en_o,
	output logic [7:0]   dout_o
);
	import mf2_pkg::*;

	logic [7:0] mem [0:(1 << `CPC_MF2_AW) - 1];
	logic [4:0] pen_index;       // Last pen selected on the gate array
	logic [3:0] crtc_reg;        // Last CRTC register selected
	mf2_addr_t  slot;
	logic       hw_sel;
	logic       ram_en;
	mf2_addr_t  ram_a;
	logic [7:0] ram_in;
	logic       ram_we;
	logic [7:0] ram_out;

	//////////////////////////////
	// Shadow slot decode

	always_comb begin
		slot = SLOT_NONE;
		casez ({bus.addr[15:8], bus.dout[7:6]})
			{8'h7F, 2'b00}: slot = SLOT_PEN;
			{8'h7F, 2'b01}: slot = pen_index[4] ? SLOT_BORDER
			                                    : SLOT_PEN_BASE + mf2_addr_t'(pen_index[3:0]);
			{8'h7F, 2'b10}: slot = SLOT_MODE;
			{8'h7F, 2'b11}: slot = SLOT_BANK;
			{8'hBC, 2'b??}: slot = SLOT_CRTC_SEL;
			{8'hBD, 2'b??}: slot = SLOT_CRTC_BASE + mf2_addr_t'(crtc_reg);
			{8'hF7, 2'b??}: slot = SLOT_PPI;
			{8'hDF, 2'b??}: slot = SLOT_UROM;
			default:        slot = SLOT_NONE;
		endcase
	end

	assign hw_sel   = hw_wr_i && (slot != SLOT_NONE);
	assign ram_en   = mf2_en_i && (bus.addr[15:13] == 3'b001);  // 2000-3FFF
	assign rom_en_o = mf2_en_i && (bus.addr[15:13] == 3'b000);  // 0000-1FFF
	assign ram_en_o = ram_en;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
			ram_we    <= 1'b0;
		end else begin
			if (hw_wr_i && bus.addr[15:8] == 8'h7F && bus.dout[7:6] == 2'b00)
				pen_index <= bus.dout[4:0];
			if (hw_wr_i && bus.addr[15:8] == 8'hBC)
				crtc_reg <= bus.dout[3:0];
			ram_we <= hw_sel || (bus.mem_wr && ram_en);
		end
	end

	//////////////////////////////
	// RAM, first stage registers the access

	always_ff @(posedge clk_sys) begin
		ram_a  <= hw_sel ? slot : bus.addr[12:0];
		ram_in <= bus.dout;
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in;   // Write through
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	assign dout_o = (ram_en && bus.mem_rd) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

//--- sim/cpc_chk.sv
// Concurrent assertions on the loader and Multiface outputs
// Bound to the top level, the count of failures is visible to the testbench
`timescale 1ns/1ps
`default_nettype none

module cpc_chk (
	input wire logic        clk_sys,
	input wire logic        reset,
	input wire logic        download_i,
	input wire logic        boot_wr_i,
	input wire logic        rom_en_i,
	input wire logic        ram_en_i,
	input wire logic        nmi_i,
	input wire logic        m1_i,
	input wire logic [15:0] cpu_addr_i
);
	int fail_count = 0;

	// Boot writes only inside a download
	boot_wr_in_download: assert property (
		@(posedge clk_sys) disable iff (reset) boot_wr_i |-> download_i
	) else begin
		$error("boot write outside a download");
		fail_count++;
	end

	rom_ram_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(rom_en_i && ram_en_i)
	) else begin
		$error("Multiface ROM and RAM enabled together");
		fail_count++;
	end

	// NMI is taken by the fetch at the vector
	nmi_clear_on_fetch: assert property (
		@(posedge clk_sys) disable iff (reset)
		$fell(nmi_i) |-> ($past(m1_i) && $past(cpu_addr_i) == 16'h0066)
	) else begin
		$error("NMI cleared without an opcode fetch at 0066");
		fail_count++;
	end

endmodule

bind cpc_loader_mf2 cpc_chk u_chk (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.download_i(ioctl_download_i),
	.boot_wr_i (boot_wr_o),
	.rom_en_i  (mf2_rom_en_o),
	.ram_en_i  (mf2_ram_en_o),
	.nmi_i     (mf2_nmi_o),
	.m1_i      (m1_i),
	.cpu_addr_i(cpu_addr_i)
);

`default_nettype wire

//--- sim/cpc_tb.sv
// Testbench for the download loader and the Multiface Two
// Runs ROM download, expansion pages, Multiface entry, shadow RAM and disabled mode in order
`timescale 1ns/1ps
`default_nettype none

module cpc_tb;
	import loader_pkg::*;
	import mf2_pkg::*;

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 16;
	localparam int ROM_CYCLES      = 90;    // 20 writes of 4 cycles
	localparam int EXT_CYCLES      = 60;
	localparam int ENTRY_CYCLES    = 30;
	localparam int SHADOW_CYCLES   = 80;
	localparam int DISABLED_CYCLES = 30;
	localparam int TOTAL_CYCLES    = 2 * RESET_CYCLES + ROM_CYCLES + EXT_CYCLES
	                                 + ENTRY_CYCLES + SHADOW_CYCLES + DISABLED_CYCLES;

	// Output selectors for the compare queue
	localparam int SEL_BOOT_A    = 0;
	localparam int SEL_BANK      = 1;
	localparam int SEL_BOOT_WR   = 2;
	localparam int SEL_BOOT_DOUT = 3;
	localparam int SEL_ROM_MAP   = 4;
	localparam int SEL_NMI       = 5;
	localparam int SEL_ROM_EN    = 6;
	localparam int SEL_RAM_EN    = 7;
	localparam int SEL_MF2_DOUT  = 8;

	localparam logic [7:0] SHADOW_PORTS [0:7] = '{8'h7F, 8'h7F, 8'h7F, 8'h7F,
	                                              8'hBC, 8'hBD, 8'hF7, 8'hDF};

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	file_ext_t   ioctl_file_ext;
	logic        model;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        m1;
	logic        io_wr;
	logic        mem_rd;
	logic        mem_wr;
	logic        key_nmi;
	mf2_mode_e   mf2_mode;
	logic        boot_wr;
	boot_addr_t  boot_a;
	boot_bank_t  boot_bank;
	logic [7:0]  boot_dout;
	rom_map_t    rom_map;
	logic        mf2_nmi;
	logic        mf2_rom_en;
	logic        mf2_ram_en;
	logic [7:0]  mf2_dout;

	string       chk_name [$];
	int          chk_sel [$];
	int          chk_arg [$];
	logic [31:0] chk_exp [$];
	logic [12:0] shadow_slot [0:7];
	logic [7:0]  shadow_val [0:7];

	cpc_loader_mf2 DUT (
		.clk_sys(clk_sys), .reset(reset),
		.ioctl_wr_i(ioctl_wr), .ioctl_addr_i(ioctl_addr), .ioctl_dout_i(ioctl_dout),
		.ioctl_download_i(ioctl_download), .ioctl_index_i(ioctl_index),
		.ioctl_file_ext_i(ioctl_file_ext), .model_i(model),
		.cpu_addr_i(cpu_addr), .cpu_dout_i(cpu_dout), .m1_i(m1), .io_wr_i(io_wr),
		.mem_rd_i(mem_rd), .mem_wr_i(mem_wr), .key_nmi_i(key_nmi), .mf2_mode_i(mf2_mode),
		.boot_wr_o(boot_wr), .boot_a_o(boot_a), .boot_bank_o(boot_bank),
		.boot_dout_o(boot_dout), .rom_map_o(rom_map), .mf2_nmi_o(mf2_nmi),
		.mf2_rom_en_o(mf2_rom_en), .mf2_ram_en_o(mf2_ram_en), .mf2_dout_o(mf2_dout)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//////////////////////////////
	// Reference model

	// Returns {boot_wr, bank, boot address}
	function automatic logic [25:0] expected_boot(input logic ext, input logic [24:0] addr,
	                                              input page_t page, input logic model_sel);
		logic       wr;
		logic [1:0] bank;
		logic [8:0] hi;
		wr   = 1'b1;
		bank = 2'd0;
		hi   = 9'h1FF;
		if (ext) begin
			hi   = {page[8], page[7:0] + addr[21:14]};
			bank = {1'b0, model_sel};
		end else if (addr[24:14] > 11'd7) begin
			wr = 1'b0;                   // Past the last ROM block
		end else begin
			case (addr[15:14])
				2'd0:    hi = 9'h000;
				2'd1:    hi = 9'h100;
				2'd2:    hi = 9'h107;
				default: hi = 9'h0FF;
			endcase
			bank = {1'b0, addr[16]};     // Blocks 4 to 7
		end
		return {wr, bank, hi, addr[13:0]};
	endfunction

	function automatic logic [3:0] hex_value(input logic [7:0] c, input logic [3:0] keep);
		if (c >= "0" && c <= "9")
			return 4'(c - 8'h30);
		if (c >= "A" && c <= "F")
			return 4'(c - 8'h37);
		return keep;
	endfunction

	function automatic page_t expected_page(input logic [15:0] ext);
		page_t p;
		p = 9'h1EE;
		if (ext == "ZZ" || ext == "Z0")
			return 9'h000;
		p[7:4] = hex_value(ext[15:8], p[7:4]);
		p[3:0] = hex_value(ext[7:0], p[3:0]);
		return p;
	endfunction

	function automatic logic [12:0] expected_slot(input logic [7:0] port, input logic [7:0] data,
	                                              input logic [4:0] pen, input logic [3:0] crtc);
		case (port)
			8'h7F: begin
				case (data[7:6])
					2'b00:   return SLOT_PEN;
					2'b01:   return pen[4] ? SLOT_BORDER : SLOT_PEN_BASE + {9'd0, pen[3:0]};
					2'b10:   return SLOT_MODE;
					default: return SLOT_BANK;
				endcase
			end
			8'hBC:   return SLOT_CRTC_SEL;
			8'hBD:   return SLOT_CRTC_BASE + {9'd0, crtc};
			8'hF7:   return SLOT_PPI;
			8'hDF:   return SLOT_UROM;
			default: return SLOT_NONE;
		endcase
	endfunction

	function automatic logic [31:0] actual_value(input int sel, input int arg);
		case (sel)
			SEL_BOOT_A:    return 32'(boot_a);
			SEL_BANK:      return 32'(boot_bank);
			SEL_BOOT_WR:   return 32'(boot_wr);
			SEL_BOOT_DOUT: return 32'(boot_dout);
			SEL_ROM_MAP:   return 32'(rom_map[arg]);
			SEL_NMI:       return 32'(mf2_nmi);
			SEL_ROM_EN:    return 32'(mf2_rom_en);
			SEL_RAM_EN:    return 32'(mf2_ram_en);
			default:       return 32'(mf2_dout);
		endcase
	endfunction

	//////////////////////////////
	// Checking

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s expected %0h actual %0h",
			                   name, expected, actual));
	endtask

	task automatic expect_out(input string name, input int sel, input int arg,
	                          input logic [31:0] value);
		chk_name.push_back(name);
		chk_sel.push_back(sel);
		chk_arg.push_back(arg);
		chk_exp.push_back(value);
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk_sys) begin
		if (DUT.u_chk.fail_count != 0)
			fail_run("A concurrent assertion on the DUT failed");
		else
			while (chk_sel.size() > 0)
				check_value(chk_name.pop_front(), chk_exp.pop_front(),
				            actual_value(chk_sel.pop_front(), chk_arg.pop_front()));
	end

	initial begin
		#(TOTAL_CYCLES * 2 * CLK_PERIOD + 100 * CLK_PERIOD);
		fail_run("Timeout, the tests did not finish in the expected time");
	end

	//////////////////////////////
	// Stimulus

	task automatic next_cycle;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic apply_reset;
		reset = 1'b1;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
	endtask

	task automatic download_write(input string name, input logic [24:0] addr, input logic ext,
	                              input page_t page);
		logic [25:0] exp;
		exp        = expected_boot(ext, addr, page, model);
		ioctl_addr = addr;
		ioctl_dout = 8'($urandom);
		ioctl_wr   = 1'b1;
		expect_out({name, " boot_wr"}, SEL_BOOT_WR, 0, 32'(exp[25]));
		expect_out({name, " bank"}, SEL_BANK, 0, 32'(exp[24:23]));
		expect_out({name, " boot_dout"}, SEL_BOOT_DOUT, 0, 32'(ioctl_dout));
		if (exp[25])
			expect_out({name, " boot_a"}, SEL_BOOT_A, 0, 32'(exp[22:0]));
		next_cycle();
		ioctl_wr = 1'b0;
		repeat (2) next_cycle();         // Write done, then map update
		if (ext && exp[22])
			expect_out({name, " rom_map"}, SEL_ROM_MAP, int'(exp[21:14]), 32'd1);
		next_cycle();
	endtask

	task automatic ext_download(input logic [15:0] ext, input logic [24:0] addr_a,
	                            input logic [24:0] addr_b);
		page_t page;
		page           = expected_page(ext);
		model          = ~model;         // Bank follows the model select
		ioctl_index    = DL_EXT;
		ioctl_file_ext = {"E", ext};
		ioctl_download = 1'b1;
		next_cycle();
		download_write($sformatf("ext %s first", ext), addr_a, 1'b1, page);
		if (ext == "Z0" && (&addr_a[13:0]))
			page = 9'h1FF;               // Combined image moves on
		download_write($sformatf("ext %s second", ext), addr_b, 1'b1, page);
		ioctl_download = 1'b0;
		next_cycle();
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = 1'b1;
		next_cycle();
		io_wr = 1'b0;
		next_cycle();
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		cpu_addr = addr;
		m1       = 1'b1;
		next_cycle();
		m1 = 1'b0;
	endtask

	task automatic key_press;
		key_nmi = 1'b1;
		next_cycle();
		key_nmi = 1'b0;
	endtask

	task automatic probe_enables(input string name, input logic [15:0] addr, input logic rom,
	                             input logic ram);
		cpu_addr = addr;
		expect_out({name, " rom_en"}, SEL_ROM_EN, 0, 32'(rom));
		expect_out({name, " ram_en"}, SEL_RAM_EN, 0, 32'(ram));
		next_cycle();
	endtask

	task automatic mf2_read(input string name, input logic [15:0] addr, input logic [7:0] value);
		cpu_addr = addr;
		mem_rd   = 1'b1;
		repeat (2) next_cycle();         // Two cycle read latency
		expect_out(name, SEL_MF2_DOUT, 0, 32'(value));
		next_cycle();
		mem_rd = 1'b0;
	endtask

	initial begin
		logic [7:0]  data;
		logic [4:0]  pen;
		logic [3:0]  crtc;
		logic [15:0] rt_addr;
		void'($urandom(36));
		reset          = 1'b1;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_download = 1'b0;
		ioctl_index    = DL_ROM;
		ioctl_file_ext = '0;
		model          = 1'b1;
		cpu_addr       = '0;
		cpu_dout       = '0;
		m1             = 1'b0;
		io_wr          = 1'b0;
		mem_rd         = 1'b0;
		mem_wr         = 1'b0;
		key_nmi        = 1'b0;
		mf2_mode       = MF2_ENABLED;
		apply_reset();

		// ROM download over blocks 0 to 9
		ioctl_index    = DL_ROM;
		ioctl_download = 1'b1;
		for (int blk = 0; blk < 10; blk++)
			repeat (2)
				download_write($sformatf("rom block %0d", blk), {11'(blk), 14'($urandom)},
				               1'b0, '0);
		ioctl_download = 1'b0;
		next_cycle();

		// Expansion pages
		ext_download("1A", 25'($urandom) & 25'h07FFF, 25'($urandom) & 25'h07FFF);
		ext_download("F0", 25'($urandom) & 25'h07FFF, 25'($urandom) & 25'h07FFF);
		ext_download("ZZ", 25'($urandom) & 25'h07FFF, 25'($urandom) & 25'h07FFF);
		ext_download("Q1", 25'($urandom) & 25'h07FFF, 25'($urandom) & 25'h07FFF);
		ext_download("Z0", 25'h03FFF, 25'h04000);

		// Multiface entry, then hide
		key_press();
		expect_out("freeze nmi", SEL_NMI, 0, 32'd1);
		next_cycle();
		m1_fetch(16'h0066);
		expect_out("nmi cleared", SEL_NMI, 0, 32'd0);
		probe_enables("entry 0066", 16'h0066, 1'b1, 1'b0);
		probe_enables("entry 1FFF", 16'h1FFF, 1'b1, 1'b0);
		probe_enables("entry 2000", 16'h2000, 1'b0, 1'b1);
		m1_fetch(16'h0065);
		probe_enables("hide 0065", 16'h0065, 1'b1, 1'b0);
		io_write(16'hFEE8, 8'($urandom));
		probe_enables("hidden FEE8", 16'h0100, 1'b0, 1'b0);

		// Enter again, page out and back in through the port
		key_press();
		expect_out("second nmi", SEL_NMI, 0, 32'd1);
		next_cycle();
		m1_fetch(16'h0066);
		io_write(16'hFEEA, 8'($urandom));
		probe_enables("after FEEA", 16'h0000, 1'b0, 1'b0);
		io_write(16'hFEE8, 8'($urandom));
		probe_enables("after FEE8", 16'h0000, 1'b1, 1'b0);

		// Shadow copies of the hardware registers
		pen  = '0;
		crtc = '0;
		for (int i = 0; i < 8; i++) begin
			data = 8'($urandom);
			if (i < 4)
				data[7:6] = 2'(i);       // Pen, color, mode, bank
			shadow_slot[i] = expected_slot(SHADOW_PORTS[i], data, pen, crtc);
			shadow_val[i]  = data;
			if (SHADOW_PORTS[i] == 8'h7F && data[7:6] == 2'b00)
				pen = data[4:0];
			if (SHADOW_PORTS[i] == 8'hBC)
				crtc = data[3:0];
			io_write({SHADOW_PORTS[i], 8'($urandom)}, data);
		end
		for (int i = 0; i < 8; i++)
			mf2_read($sformatf("shadow %0d slot %h", i, shadow_slot[i]),
			         16'h2000 + 16'(shadow_slot[i]), shadow_val[i]);
		rt_addr  = 16'h2000 | 16'(13'($urandom));
		data     = 8'($urandom);
		cpu_addr = rt_addr;
		cpu_dout = data;
		mem_wr   = 1'b1;
		next_cycle();
		mem_wr = 1'b0;
		next_cycle();
		mf2_read("mem_wr round trip", rt_addr, data);

		// Disabled mode
		mf2_mode = MF2_DISABLED;
		apply_reset();
		key_press();
		expect_out("disabled nmi", SEL_NMI, 0, 32'd0);
		next_cycle();
		io_write(16'hFEE8, 8'($urandom));
		expect_out("disabled nmi after FEE8", SEL_NMI, 0, 32'd0);
		probe_enables("disabled 0000", 16'h0000, 1'b0, 1'b0);
		probe_enables("disabled 2000", 16'h2000, 1'b0, 1'b0);
		mf2_read("disabled dout", 16'h2100, 8'hFF);
		expect_out("idle dout", SEL_MF2_DOUT, 0, 32'hFF);
		next_cycle();

		if (DUT.u_chk.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			fail_run("A concurrent assertion on the DUT failed");
		end
	end

endmodule

`default_nettype wire
